// File: all.f
ts_pkg.sv
ts_bank_ram.sv
ts_burst_writer.sv
dma_read_fsm.sv
dma_beat_output.sv
ts_pingpong_top.sv
tb_ts_pingpong_asserts.sv
tb_ts_pingpong.sv

// File: tb_ts_pingpong.sv
`timescale 1ns/10ps

module tb_ts_pingpong;

   localparam int BANK_DEPTH    = 64;
   localparam int TRAILER_BEATS = 8;
   localparam int FILL_BEATS    = 80;
   localparam int WAIT_LIMIT    = 200;

   logic             clk_pcie;
   logic             rst_pcie;
   logic             ts_ram_wr;
   ts_pkg::ts_word_t ts_ram_wdata;
   logic             dma_write_start;
   logic             dma_raddr_en;
   logic [31:0]      dma_raddr;
   logic             dma_write_end;
   ts_pkg::ts_word_t dma_rdata;
   logic             dma_rdata_rdy;

   // reference model holding one burst per bank
   ts_pkg::ts_word_t model_mem [2][BANK_DEPTH];
   logic             model_full [2];
   int               wr_bank;
   int               rd_bank;

   logic [15:0] lfsr;
   int          check_cnt;
   int          err_cnt;
   logic        aborted;

   ts_pingpong_top UUT (.*);

   initial begin
      clk_pcie = 1'b0;
      forever #10 clk_pcie = ~clk_pcie;
   end

   ////////////////////
   // helpers

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
   endtask

   // lowest source byte ends up on top
   function automatic ts_pkg::ts_word_t reverse_bytes(input ts_pkg::ts_word_t w);
      ts_pkg::ts_word_t r;
      ts_pkg::ts_word_t t;
      r = '0;
      t = w;
      repeat (8) begin
         r = {r[55:0], t[7:0]};
         t = t >> 8;
      end
      return r;
   endfunction

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      err_cnt++;
      aborted = 1'b1;
      $display("timeout at %0t ns while waiting for %s", $time, what);
   endtask

   task automatic end_test(input string name, input int errs_before);
      $display("test %s finished with %0d mismatches", name, err_cnt - errs_before);
   endtask

   ////////////////////
   // bus activity

   task automatic write_burst();
      logic [63:0] word;
      logic        accept;
      if (aborted)
         return;
      // a full bank makes the writer ignore the whole burst
      accept = !model_full[wr_bank];
      for (int i = 0; i < BANK_DEPTH; i++) begin
         take_bits(64, word);
         @(negedge clk_pcie);
         ts_ram_wr    = 1'b1;
         ts_ram_wdata = word;
         if (accept)
            model_mem[wr_bank][i] = word;
      end
      @(negedge clk_pcie);
      ts_ram_wr = 1'b0;
      // room for the mark and free states
      repeat (4) @(negedge clk_pcie);
      if (accept) begin
         model_full[wr_bank] = 1'b1;
         wr_bank             = 1 - wr_bank;
      end
   endtask

   task automatic run_session(input string name);
      logic        full;
      int          expect_beats;
      int          n;
      int          t;
      logic [63:0] exp;
      if (aborted)
         return;
      full         = model_full[rd_bank];
      expect_beats = full ? BANK_DEPTH + TRAILER_BEATS : FILL_BEATS;
      @(negedge clk_pcie);
      dma_write_start = 1'b1;
      @(negedge clk_pcie);
      dma_write_start = 1'b0;
      repeat (2) @(negedge clk_pcie);
      dma_raddr_en = 1'b1;
      @(negedge clk_pcie);
      dma_raddr_en = 1'b0;
      t = 0;
      while (!dma_rdata_rdy && !aborted) begin
         @(negedge clk_pcie);
         t++;
         if (t > WAIT_LIMIT)
            report_timeout({name, " first beat"});
      end
      n = 0;
      while (dma_rdata_rdy && !aborted) begin
         if (full && n < BANK_DEPTH)
            exp = reverse_bytes(model_mem[rd_bank][n]);
         else
            exp = '0;
         check_value(dma_rdata, exp, $sformatf("%s beat %0d", name, n));
         n++;
         @(negedge clk_pcie);
         if (n > WAIT_LIMIT)
            report_timeout({name, " end of beats"});
      end
      if (aborted)
         return;
      check_value(n, expect_beats, {name, " beat count"});
      dma_write_end = 1'b1;
      @(negedge clk_pcie);
      dma_write_end = 1'b0;
      repeat (3) @(negedge clk_pcie);
      // only a full bank is released and swapped
      if (full) begin
         model_full[rd_bank] = 1'b0;
         rd_bank             = 1 - rd_bank;
      end
   endtask

   ////////////////////
   // test sequence

   initial begin
      int          e;
      logic [63:0] pick;
      rst_pcie        = 1'b1;
      ts_ram_wr       = 1'b0;
      ts_ram_wdata    = '0;
      dma_write_start = 1'b0;
      dma_raddr_en    = 1'b0;
      dma_raddr       = '0;
      dma_write_end   = 1'b0;
      lfsr            = 16'd12038;
      check_cnt       = 0;
      err_cnt         = 0;
      aborted         = 1'b0;
      model_full[0]   = 1'b0;
      model_full[1]   = 1'b0;
      wr_bank         = 0;
      rd_bank         = 0;
      repeat (2) @(posedge clk_pcie);
      @(negedge clk_pcie);
      rst_pcie = 1'b0;

      e = err_cnt;
      repeat (4) begin
         @(negedge clk_pcie);
         check_value(dma_rdata_rdy, 1'b0, "rdy after reset");
         check_value(dma_rdata, '0, "rdata after reset");
      end
      end_test("reset state", e);

      e = err_cnt;
      write_burst();
      run_session("full bank");
      end_test("full bank readout", e);

      e = err_cnt;
      run_session("empty bank");
      write_burst();
      run_session("after empty");
      end_test("empty response", e);

      e = err_cnt;
      write_burst();
      write_burst();
      run_session("ping");
      run_session("pong");
      run_session("drained");
      end_test("ping-pong", e);

      e = err_cnt;
      write_burst();
      write_burst();
      write_burst();
      run_session("kept first");
      run_session("kept second");
      run_session("dropped third");
      end_test("drop while full", e);

      e = err_cnt;
      for (int i = 0; i < 20; i++) begin
         take_bits(1, pick);
         if (pick[0])
            write_burst();
         else
            run_session($sformatf("random step %0d", i));
      end
      end_test("randomized run", e);

      $display("checks %0d, mismatches and timeouts %0d, assertion failures %0d",
               check_cnt, err_cnt, UUT.u_asserts.fail_cnt);
      if (err_cnt == 0 && UUT.u_asserts.fail_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: tb_ts_pingpong_asserts.sv
`timescale 1ns/10ps

module tb_ts_pingpong_asserts (
   input logic              clk_pcie,
   input logic              rst_pcie,
   input logic              dma_write_start,
   input logic              dma_raddr_en,
   input logic              dma_rdata_rdy,
   input ts_pkg::rd_state_e seq_state
);

   logic addr_seen;
   logic beats_seen;
   int   fail_cnt = 0;

   // per-session history cleared by the session start pulse
   always_ff @(posedge clk_pcie) begin
      if (rst_pcie || dma_write_start) begin
         addr_seen  <= 1'b0;
         beats_seen <= 1'b0;
      end else begin
         if (dma_raddr_en)
            addr_seen <= 1'b1;
         if (dma_rdata_rdy)
            beats_seen <= 1'b1;
      end
   end

   reset_rdy_low: assert property (@(posedge clk_pcie) rst_pcie |=> !dma_rdata_rdy)
      else begin
         $error("dma_rdata_rdy high right after reset");
         fail_cnt++;
      end

   rdy_after_addr: assert property (@(posedge clk_pcie) disable iff (rst_pcie)
      $rose(dma_rdata_rdy) |-> addr_seen)
      else begin
         $error("beats started without dma_raddr_en in this session");
         fail_cnt++;
      end

   beats_contiguous: assert property (@(posedge clk_pcie) disable iff (rst_pcie)
      $rose(dma_rdata_rdy) |-> !beats_seen)
      else begin
         $error("second run of beats inside one session");
         fail_cnt++;
      end

   ////////////////////
   // output pipeline is two deep and needs two cycles to drain
   quiet_at_end: assert property (@(posedge clk_pcie) disable iff (rst_pcie)
      (seq_state inside {ts_pkg::RD_WAIT_END, ts_pkg::RD_FILL_END}) &&
      ($past(seq_state, 2) inside {ts_pkg::RD_RELEASE, ts_pkg::RD_WAIT_END,
                                   ts_pkg::RD_FILL_END})
      |-> !dma_rdata_rdy)
      else begin
         $error("dma_rdata_rdy high while waiting for dma_write_end");
         fail_cnt++;
      end

endmodule

bind ts_pingpong_top tb_ts_pingpong_asserts u_asserts (
   .clk_pcie,
   .rst_pcie,
   .dma_write_start,
   .dma_raddr_en,
   .dma_rdata_rdy,
   .seq_state(u_seq.state_q)
);

// File: ts_pingpong_top.sv
`timescale 1ns/10ps

module ts_pingpong_top #(
   parameter int BANK_DEPTH    = 64,
   parameter int TRAILER_BEATS = 8,
   parameter int FILL_BEATS    = 80,
   parameter int PAUSE_CYCLES  = 12
) (
   input  logic             clk_pcie,
   input  logic             rst_pcie,
   input  logic             ts_ram_wr,
   input  ts_pkg::ts_word_t ts_ram_wdata,
   input  logic             dma_write_start,
   input  logic             dma_raddr_en,
   // kept for port compatibility, not used
   input  logic [31:0]      dma_raddr,
   input  logic             dma_write_end,
   output ts_pkg::ts_word_t dma_rdata,
   output logic             dma_rdata_rdy
);

   localparam int AW = $clog2(BANK_DEPTH);

   ts_pkg::bank_wr_t bank_wr;
   ts_pkg::rd_cmd_t  rd_cmd;
   ts_pkg::ts_word_t rd_data_a;
   ts_pkg::ts_word_t rd_data_b;
   logic             wr_en_a;
   logic             wr_en_b;
   logic             full_a;
   logic             full_b;
   logic             release_a;
   logic             release_b;

   ////////////////////
   // write side

   ts_burst_writer #(.BANK_DEPTH(BANK_DEPTH)) u_writer (
      .clk_pcie, .rst_pcie, .ts_ram_wr, .ts_ram_wdata, .release_a, .release_b,
      .bank_wr, .wr_en_a, .wr_en_b, .full_a, .full_b
   );

   ts_bank_ram #(.DEPTH(BANK_DEPTH)) u_bank_a (
      .clk_pcie, .wr_en(wr_en_a), .bank_wr, .rd_addr(rd_cmd.addr[AW-1:0]),
      .rd_data(rd_data_a)
   );

   ts_bank_ram #(.DEPTH(BANK_DEPTH)) u_bank_b (
      .clk_pcie, .wr_en(wr_en_b), .bank_wr, .rd_addr(rd_cmd.addr[AW-1:0]),
      .rd_data(rd_data_b)
   );

   ////////////////////
   // dma side

   dma_read_fsm #(
      .BANK_DEPTH(BANK_DEPTH), .TRAILER_BEATS(TRAILER_BEATS),
      .FILL_BEATS(FILL_BEATS), .PAUSE_CYCLES(PAUSE_CYCLES)
   ) u_seq (
      .clk_pcie, .rst_pcie, .dma_write_start, .dma_raddr_en, .dma_write_end,
      .full_a, .full_b, .release_a, .release_b, .rd_cmd
   );

   dma_beat_output u_out (
      .clk_pcie, .rst_pcie, .rd_cmd, .rd_data_a, .rd_data_b, .dma_rdata, .dma_rdata_rdy
   );

endmodule

// File: dma_beat_output.sv
`timescale 1ns/10ps

module dma_beat_output (
   input  logic             clk_pcie,
   input  logic             rst_pcie,
   input  ts_pkg::rd_cmd_t  rd_cmd,
   input  ts_pkg::ts_word_t rd_data_a,
   input  ts_pkg::ts_word_t rd_data_b,
   output ts_pkg::ts_word_t dma_rdata,
   output logic             dma_rdata_rdy
);

   ts_pkg::rd_cmd_t  cmd_q;
   ts_pkg::ts_word_t sel_word;

   // host expects the first stream byte in the low lane
   function automatic ts_pkg::ts_word_t byte_swap(input ts_pkg::ts_word_t w);
      ts_pkg::ts_word_t r;
      for (int i = 0; i < 8; i++) begin
         r[8*i +: 8] = w[56-8*i +: 8];
      end
      return r;
   endfunction

   // command delayed to meet the ram read data
   always_ff @(posedge clk_pcie) begin
      if (rst_pcie)
         cmd_q <= '0;
      else
         cmd_q <= rd_cmd;
   end

   assign sel_word = (cmd_q.bank == ts_pkg::BANK_A) ? rd_data_a : rd_data_b;

   ////////////////////
   // output register

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         dma_rdata     <= '0;
         dma_rdata_rdy <= 1'b0;
      end else begin
         dma_rdata_rdy <= (cmd_q.kind != ts_pkg::BEAT_NONE);
         // trailer and fill beats go out as zero
         if (cmd_q.kind == ts_pkg::BEAT_DATA)
            dma_rdata <= byte_swap(sel_word);
         else
            dma_rdata <= '0;
      end
   end

endmodule

// File: dma_read_fsm.sv
`timescale 1ns/10ps

module dma_read_fsm #(
   parameter int BANK_DEPTH    = 64,
   parameter int TRAILER_BEATS = 8,
   parameter int FILL_BEATS    = 80,
   parameter int PAUSE_CYCLES  = 12
) (
   input  logic            clk_pcie,
   input  logic            rst_pcie,
   input  logic            dma_write_start,
   input  logic            dma_raddr_en,
   input  logic            dma_write_end,
   input  logic            full_a,
   input  logic            full_b,
   output logic            release_a,
   output logic            release_b,
   output ts_pkg::rd_cmd_t rd_cmd
);

   ts_pkg::rd_state_e  state_q;
   ts_pkg::rd_state_e  state_d;
   ts_pkg::bank_sel_e  bank_q;
   logic               fill_q;
   logic               cur_full;
   logic               counting;
   logic               phase_done;
   ts_pkg::bank_addr_t cnt_q;
   ts_pkg::bank_addr_t phase_len;

   assign cur_full = (bank_q == ts_pkg::BANK_A) ? full_a : full_b;

   ////////////////////
   // phase lengths for the shared counter

   always_comb begin
      case (state_q)
         ts_pkg::RD_PAUSE:   phase_len = ts_pkg::bank_addr_t'(PAUSE_CYCLES);
         ts_pkg::RD_DATA:    phase_len = ts_pkg::bank_addr_t'(BANK_DEPTH);
         ts_pkg::RD_TRAILER: phase_len = ts_pkg::bank_addr_t'(TRAILER_BEATS);
         ts_pkg::RD_FILL:    phase_len = ts_pkg::bank_addr_t'(FILL_BEATS);
         default:            phase_len = ts_pkg::bank_addr_t'(1);
      endcase
   end

   assign counting   = (state_q == ts_pkg::RD_PAUSE) || (state_q == ts_pkg::RD_DATA) ||
                       (state_q == ts_pkg::RD_TRAILER) || (state_q == ts_pkg::RD_FILL);
   assign phase_done = (cnt_q == phase_len - 1'b1);

   ////////////////////
   // session sequencing

   always_comb begin
      state_d = state_q;
      case (state_q)
         ts_pkg::RD_IDLE:
            if (dma_write_start)
               state_d = ts_pkg::RD_CHECK;
         ts_pkg::RD_CHECK:
            state_d = ts_pkg::RD_WAIT_ADDR;
         ts_pkg::RD_WAIT_ADDR:
            if (dma_raddr_en)
               state_d = ts_pkg::RD_PAUSE;
         ts_pkg::RD_PAUSE:
            if (phase_done)
               state_d = fill_q ? ts_pkg::RD_FILL : ts_pkg::RD_DATA;
         ts_pkg::RD_DATA:
            if (phase_done)
               state_d = ts_pkg::RD_TRAILER;
         ts_pkg::RD_TRAILER:
            if (phase_done)
               state_d = ts_pkg::RD_RELEASE;
         ts_pkg::RD_RELEASE:
            state_d = ts_pkg::RD_WAIT_END;
         ts_pkg::RD_WAIT_END:
            if (dma_write_end)
               state_d = ts_pkg::RD_IDLE;
         ts_pkg::RD_FILL:
            if (phase_done)
               state_d = ts_pkg::RD_FILL_END;
         ts_pkg::RD_FILL_END:
            if (dma_write_end)
               state_d = ts_pkg::RD_IDLE;
         default:
            state_d = ts_pkg::RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         state_q <= ts_pkg::RD_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         // restart on every phase change
         if (!counting || state_d != state_q)
            cnt_q <= '0;
         else
            cnt_q <= cnt_q + 1'b1;
      end
   end

   // bank choice is made once per session
   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         bank_q <= ts_pkg::BANK_A;
         fill_q <= 1'b0;
      end else begin
         if (state_q == ts_pkg::RD_CHECK)
            fill_q <= !cur_full;
         // empty sessions stay on the same bank
         if (state_q == ts_pkg::RD_WAIT_END && dma_write_end)
            bank_q <= (bank_q == ts_pkg::BANK_A) ? ts_pkg::BANK_B : ts_pkg::BANK_A;
      end
   end

   assign release_a = (state_q == ts_pkg::RD_RELEASE) && (bank_q == ts_pkg::BANK_A);
   assign release_b = (state_q == ts_pkg::RD_RELEASE) && (bank_q == ts_pkg::BANK_B);

   ////////////////////
   // beat commands, one per cycle

   always_comb begin
      rd_cmd      = '0;
      rd_cmd.bank = bank_q;
      case (state_q)
         ts_pkg::RD_DATA: begin
            rd_cmd.kind = ts_pkg::BEAT_DATA;
            rd_cmd.addr = cnt_q;
         end
         ts_pkg::RD_TRAILER:
            rd_cmd.kind = ts_pkg::BEAT_TRAILER;
         ts_pkg::RD_FILL:
            rd_cmd.kind = ts_pkg::BEAT_FILL;
         default:
            rd_cmd.kind = ts_pkg::BEAT_NONE;
      endcase
   end

endmodule

// File: ts_burst_writer.sv
`timescale 1ns/10ps

module ts_burst_writer #(
   parameter int BANK_DEPTH = 64
) (
   input  logic              clk_pcie,
   input  logic              rst_pcie,
   input  logic              ts_ram_wr,
   input  ts_pkg::ts_word_t  ts_ram_wdata,
   input  logic              release_a,
   input  logic              release_b,
   output ts_pkg::bank_wr_t  bank_wr,
   output logic              wr_en_a,
   output logic              wr_en_b,
   output logic              full_a,
   output logic              full_b
);

   localparam ts_pkg::bank_addr_t LAST_ADDR = ts_pkg::bank_addr_t'(BANK_DEPTH - 1);

   ts_pkg::wr_state_e  state_q;
   ts_pkg::wr_state_e  state_d;
   logic               ts_ram_wr_d;
   logic               wr_rise;
   logic               burst_start;
   logic               wr_we;
   ts_pkg::bank_addr_t wr_addr;
   ts_pkg::ts_word_t   wr_data;

   // strobe edge, only taken while waiting on a free bank
   assign wr_rise     = ts_ram_wr && !ts_ram_wr_d;
   assign burst_start = wr_rise &&
                        (state_q == ts_pkg::WR_START_A || state_q == ts_pkg::WR_START_B);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ts_pkg::WR_FREE_A:  if (!full_a) state_d = ts_pkg::WR_START_A;
         ts_pkg::WR_START_A: if (wr_rise) state_d = ts_pkg::WR_BURST_A;
         ts_pkg::WR_BURST_A: if (!ts_ram_wr) state_d = ts_pkg::WR_MARK_A;
         ts_pkg::WR_MARK_A:  state_d = ts_pkg::WR_FREE_B;
         ts_pkg::WR_FREE_B:  if (!full_b) state_d = ts_pkg::WR_START_B;
         ts_pkg::WR_START_B: if (wr_rise) state_d = ts_pkg::WR_BURST_B;
         ts_pkg::WR_BURST_B: if (!ts_ram_wr) state_d = ts_pkg::WR_MARK_B;
         ts_pkg::WR_MARK_B:  state_d = ts_pkg::WR_FREE_A;
         default:            state_d = ts_pkg::WR_FREE_A;
      endcase
   end

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         state_q     <= ts_pkg::WR_FREE_A;
         ts_ram_wr_d <= 1'b0;
      end else begin
         state_q     <= state_d;
         ts_ram_wr_d <= ts_ram_wr;
      end
   end

   ////////////////////
   // write port, one cycle behind the strobe

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         wr_we   <= 1'b0;
         wr_addr <= '0;
      end else if (burst_start) begin
         wr_we   <= 1'b1;
         wr_addr <= '0;
      end else if (state_q == ts_pkg::WR_BURST_A || state_q == ts_pkg::WR_BURST_B) begin
         wr_we <= ts_ram_wr;
         // long bursts pile up on the last word
         if (ts_ram_wr && wr_addr != LAST_ADDR)
            wr_addr <= wr_addr + 1'b1;
      end else begin
         wr_we   <= 1'b0;
         wr_addr <= '0;
      end
   end

   always_ff @(posedge clk_pcie) begin
      wr_data <= ts_ram_wdata;
   end

   assign bank_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

   // a pending write always belongs to the bank in burst
   assign wr_en_a = wr_we && (state_q == ts_pkg::WR_BURST_A);
   assign wr_en_b = wr_we && (state_q == ts_pkg::WR_BURST_B);

   ////////////////////
   // full flags

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         full_a <= 1'b0;
         full_b <= 1'b0;
      end else begin
         if (state_q == ts_pkg::WR_MARK_A)
            full_a <= 1'b1;
         else if (release_a)
            full_a <= 1'b0;
         if (state_q == ts_pkg::WR_MARK_B)
            full_b <= 1'b1;
         else if (release_b)
            full_b <= 1'b0;
      end
   end

endmodule

// File: ts_bank_ram.sv
`timescale 1ns/10ps

module ts_bank_ram #(
   parameter int DEPTH = 64
) (
   input  logic                     clk_pcie,
   input  logic                     wr_en,
   input  ts_pkg::bank_wr_t         bank_wr,
   input  logic [$clog2(DEPTH)-1:0] rd_addr,
   output ts_pkg::ts_word_t         rd_data
);

   localparam int AW = $clog2(DEPTH);

   ts_pkg::ts_word_t mem [DEPTH];

   // write side uses only the low address bits
   always_ff @(posedge clk_pcie) begin
      if (wr_en)
         mem[bank_wr.addr[AW-1:0]] <= bank_wr.data;
   end

   // registered read, data one cycle after the address
   always_ff @(posedge clk_pcie) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: ts_pkg.sv
package ts_pkg;

   ////////////////////
   // data words and addresses

   // one transport-stream word as the source delivers it
   typedef logic [63:0] ts_word_t;

   // wide enough for any legal bank depth, rams take the low bits
   typedef logic [15:0] bank_addr_t;

   typedef enum logic {
      BANK_A,
      BANK_B
   } bank_sel_e;

   ////////////////////
   // state machines

   typedef enum logic [2:0] {
      WR_FREE_A,
      WR_START_A,
      WR_BURST_A,
      WR_MARK_A,
      WR_FREE_B,
      WR_START_B,
      WR_BURST_B,
      WR_MARK_B
   } wr_state_e;

   typedef enum logic [3:0] {
      RD_IDLE,
      RD_CHECK,
      RD_WAIT_ADDR,
      RD_PAUSE,
      RD_DATA,
      RD_TRAILER,
      RD_RELEASE,
      RD_WAIT_END,
      RD_FILL,
      RD_FILL_END
   } rd_state_e;

   // beat opcodes from the sequencer to the output stage
   typedef enum logic [1:0] {
      BEAT_NONE,
      BEAT_DATA,
      BEAT_TRAILER,
      BEAT_FILL
   } beat_kind_e;

   ////////////////////
   // bundles between blocks

   typedef struct packed {
      logic       we;
      bank_addr_t addr;
      ts_word_t   data;
   } bank_wr_t;

   typedef struct packed {
      beat_kind_e kind;
      bank_sel_e  bank;
      bank_addr_t addr;
   } rd_cmd_t;

endpackage
